/* include/osd_params.svh */
// osd geometry and reset values; window sizes assume 2 clocks per pixel and 8 lines per row
`ifndef OSD_PARAMS_SVH
`define OSD_PARAMS_SVH

// --------------------
// buffer geometry
// --------------------
// 8 text rows of 8 pixel lines, 256 columns each
`define OSD_ROWS 8
`define OSD_COLS 256
`define OSD_BUF_DEPTH (`OSD_ROWS * `OSD_COLS)

// --------------------
// beam window
// --------------------
// horizontal in clocks, one pixel is two clocks
`define OSD_H_START 896
`define OSD_H_LEN (`OSD_COLS * 2)
// vertical in lines
`define OSD_V_START 128
`define OSD_V_LEN (`OSD_ROWS * 8)

// reset values
`define OSD_MEM_CFG_RESET 6'b000101
// bit 3 set means no row highlighted
`define OSD_HIGHLIGHT_NONE 4'b1000

`endif

/* hw/osd_pkg.sv */
// shared osd types; command codes are the top six bits of a command byte
package osd_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [10:0] buf_addr_t;
  typedef logic [10:0] h_count_t;
  typedef logic [8:0]  v_count_t;
  // bit 3 set = no highlight, bits 2:0 = row
  typedef logic [3:0]  highlight_t;

  // command codes, byte[7:2]
  typedef enum logic [5:0] {
    RESET_CTRL   = 6'b000010,
    OSD_CTRL     = 6'b001010,
    CHIP_CFG     = 6'b000001,
    CPU_CFG      = 6'b000101,
    MEMORY_CFG   = 6'b001001,
    VIDEO_CFG    = 6'b001101,
    FLOPPY_CFG   = 6'b010001,
    HARDDISK_CFG = 6'b010101,
    JOYSTICK_CFG = 6'b011001,
    OSD_BUFFER   = 6'b000011
  } cmd_code_t;

  // who owns a decoded write
  typedef enum logic [3:0] {
    TGT_RESET_CTRL, TGT_OSD_CTRL, TGT_CHIP, TGT_CPU, TGT_MEMORY, TGT_VIDEO,
    TGT_FLOPPY, TGT_HARDDISK, TGT_JOYSTICK, TGT_LINE, TGT_BUF
  } wr_target_t;

  typedef enum logic [2:0] {
    ST_IDLE, ST_REG, ST_LINE, ST_STREAM, ST_IGNORE
  } cmd_state_t;

endpackage

/* hw/osd_cmd_if.sv */
// decoded write bus; wr_valid is a one-cycle pulse with no acknowledge
`timescale 1ns/10ps

interface osd_cmd_if;

  logic                   wr_valid;
  osd_pkg::wr_target_t    wr_target;
  osd_pkg::byte_t         wr_data;
  // only meaningful for TGT_BUF
  osd_pkg::buf_addr_t     wr_addr;

  modport fsm (output wr_valid, output wr_target, output wr_data, output wr_addr);
  // register bank ignores the address
  modport regs (input wr_valid, input wr_target, input wr_data);
  modport buffer (input wr_valid, input wr_target, input wr_data, input wr_addr);

endinterface

/* hw/osd_cmd_fsm.sv */
// byte decoder; expects deframed byte strobes at least 2 cycles apart, line byte first for buffer writes
`timescale 1ns/10ps
`include "osd_params.svh"

module osd_cmd_fsm (
  input  logic           clk,
  input  logic           reset,
  input  logic           rx_valid,
  input  logic           rx_cmd,
  input  osd_pkg::byte_t rx_data,
  osd_cmd_if.fsm         cmd
);

  osd_pkg::cmd_state_t state;
  osd_pkg::cmd_code_t  code;
  osd_pkg::cmd_state_t code_state;
  osd_pkg::wr_target_t code_target;
  // target latched from the last config command
  osd_pkg::wr_target_t reg_target;
  osd_pkg::buf_addr_t  addr_cnt;

  // --------------------
  // command decode
  // --------------------
  always_comb begin
    code        = osd_pkg::cmd_code_t'(rx_data[7:2]);
    code_state  = osd_pkg::ST_REG;
    code_target = osd_pkg::TGT_RESET_CTRL;
    case (code)
      osd_pkg::RESET_CTRL:   code_target = osd_pkg::TGT_RESET_CTRL;
      osd_pkg::OSD_CTRL:     code_target = osd_pkg::TGT_OSD_CTRL;
      osd_pkg::CHIP_CFG:     code_target = osd_pkg::TGT_CHIP;
      osd_pkg::CPU_CFG:      code_target = osd_pkg::TGT_CPU;
      osd_pkg::MEMORY_CFG:   code_target = osd_pkg::TGT_MEMORY;
      osd_pkg::VIDEO_CFG:    code_target = osd_pkg::TGT_VIDEO;
      osd_pkg::FLOPPY_CFG:   code_target = osd_pkg::TGT_FLOPPY;
      osd_pkg::HARDDISK_CFG: code_target = osd_pkg::TGT_HARDDISK;
      osd_pkg::JOYSTICK_CFG: code_target = osd_pkg::TGT_JOYSTICK;
      osd_pkg::OSD_BUFFER:   code_state  = osd_pkg::ST_LINE;
      // unknown or dropped command, swallow its data
      default:               code_state  = osd_pkg::ST_IGNORE;
    endcase
  end

  // --------------------
  // state and strobe
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= osd_pkg::ST_IDLE;
      cmd.wr_valid <= 1'b0;
    end else begin
      cmd.wr_valid <= 1'b0;
      // a command byte always restarts decoding
      if (rx_valid && rx_cmd) begin
        state <= code_state;
      end else if (rx_valid) begin
        case (state)
          osd_pkg::ST_REG: begin
            cmd.wr_valid <= 1'b1;
            // one data byte per register write
            state        <= osd_pkg::ST_IGNORE;
          end
          osd_pkg::ST_LINE: begin
            cmd.wr_valid <= 1'b1;
            state        <= osd_pkg::ST_STREAM;
          end
          osd_pkg::ST_STREAM: cmd.wr_valid <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // payload and address counter
  always_ff @(posedge clk) begin
    if (rx_valid && rx_cmd) begin
      reg_target <= code_target;
    end
    if (rx_valid && !rx_cmd) begin
      cmd.wr_data <= rx_data;
      cmd.wr_addr <= addr_cnt;
      case (state)
        osd_pkg::ST_REG: cmd.wr_target <= reg_target;
        osd_pkg::ST_LINE: begin
          cmd.wr_target <= osd_pkg::TGT_LINE;
          // line number selects a 256-byte row
          addr_cnt      <= osd_pkg::buf_addr_t'(rx_data[2:0]) << $clog2(`OSD_COLS);
        end
        osd_pkg::ST_STREAM: begin
          cmd.wr_target <= osd_pkg::TGT_BUF;
          addr_cnt      <= addr_cnt + 11'd1;
        end
        default: ;
      endcase
    end
  end

  a_state_legal : assert property (@(posedge clk) disable iff (reset)
    !$isunknown(state) && state inside {osd_pkg::ST_IDLE, osd_pkg::ST_REG,
      osd_pkg::ST_LINE, osd_pkg::ST_STREAM, osd_pkg::ST_IGNORE});

endmodule

/* hw/osd_beam_counter.sv */
// local beam position; sof must coincide with an sol, counts wrap if strobes go missing
`timescale 1ns/10ps

module osd_beam_counter (
  input  logic              clk,
  input  logic              reset,
  input  logic              sol,
  input  logic              sof,
  output osd_pkg::h_count_t h_count,
  output osd_pkg::v_count_t v_count,
  output logic              frame_start
);

  // --------------------
  // horizontal
  // --------------------
  // clocks since start of line
  always_ff @(posedge clk) begin
    if (reset || sol) begin
      h_count <= '0;
    end else begin
      h_count <= h_count + 11'd1;
    end
  end

  // --------------------
  // vertical
  // --------------------
  // lines since start of frame, frame marker lines up with the cleared counts
  always_ff @(posedge clk) begin
    if (reset) begin
      v_count     <= '0;
      frame_start <= 1'b0;
    end else begin
      frame_start <= sof;
      if (sof) begin
        v_count <= '0;
      end else if (sol) begin
        v_count <= v_count + 9'd1;
      end
    end
  end

endmodule

/* hw/osd_config_regs.sv */
// machine settings; chipset bit 1, cpu, memory and ide only move while cpu_reset is high
`timescale 1ns/10ps
`include "osd_params.svh"

module osd_config_regs (
  input  logic                clk,
  input  logic                reset,
  osd_cmd_if.regs             cmd,
  output logic                osd_enable,
  output logic                key_disable,
  output logic                usr_reset,
  output logic                cpu_reset,
  output logic                cpu_halt,
  output logic [1:0]          lr_filter,
  output logic [1:0]          hr_filter,
  output logic [1:0]          scanline,
  output logic [3:0]          chipset_config,
  output logic [3:0]          cpu_config,
  output logic [5:0]          memory_config,
  output logic [3:0]          floppy_config,
  output logic [2:0]          ide_config,
  output logic [1:0]          autofire_config,
  output osd_pkg::highlight_t highlight
);

  // staging registers copied out under cpu reset
  logic       chip_stage;
  logic [3:0] cpu_stage;
  logic [5:0] mem_stage;
  logic [2:0] ide_stage;

  // --------------------
  // register writes
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      {cpu_halt, cpu_reset, usr_reset} <= 3'b110;
      {key_disable, osd_enable}        <= 2'b00;
      {hr_filter, lr_filter, scanline} <= 6'd0;
      chipset_config  <= 4'd0;
      floppy_config   <= 4'd0;
      autofire_config <= 2'd0;
      cpu_config      <= 4'd0;
      memory_config   <= `OSD_MEM_CFG_RESET;
      ide_config      <= 3'd0;
      chip_stage      <= 1'b0;
      cpu_stage       <= 4'd0;
      mem_stage       <= `OSD_MEM_CFG_RESET;
      ide_stage       <= 3'd0;
    end else begin
      if (cmd.wr_valid) begin
        case (cmd.wr_target)
          osd_pkg::TGT_RESET_CTRL: {cpu_halt, cpu_reset, usr_reset} <= cmd.wr_data[2:0];
          osd_pkg::TGT_OSD_CTRL:   {key_disable, osd_enable} <= cmd.wr_data[1:0];
          osd_pkg::TGT_CHIP: begin
            // bits 3,2,0 apply at once while bit 1 waits for cpu reset
            chipset_config[3:2] <= cmd.wr_data[3:2];
            chipset_config[0]   <= cmd.wr_data[0];
            chip_stage          <= cmd.wr_data[1];
          end
          osd_pkg::TGT_CPU:        cpu_stage <= cmd.wr_data[3:0];
          osd_pkg::TGT_MEMORY:     mem_stage <= cmd.wr_data[5:0];
          osd_pkg::TGT_VIDEO:      {hr_filter, lr_filter, scanline} <= cmd.wr_data[5:0];
          osd_pkg::TGT_FLOPPY:     floppy_config <= cmd.wr_data[3:0];
          osd_pkg::TGT_HARDDISK:   ide_stage <= cmd.wr_data[2:0];
          osd_pkg::TGT_JOYSTICK:   autofire_config <= cmd.wr_data[1:0];
          default: ;
        endcase
      end
      // copy out only while the cpu is held in reset
      if (cpu_reset) begin
        chipset_config[1] <= chip_stage;
        cpu_config        <= cpu_stage;
        memory_config     <= mem_stage;
        ide_config        <= ide_stage;
      end
    end
  end

  // row highlight comes from the line byte and drops whenever osd is off
  always_ff @(posedge clk) begin
    if (reset || !osd_enable) begin
      highlight <= `OSD_HIGHLIGHT_NONE;
    end else if (cmd.wr_valid && cmd.wr_target == osd_pkg::TGT_LINE && cmd.wr_data[4]) begin
      highlight <= cmd.wr_data[3:0];
    end
  end

  // decoded writes arrive as single-cycle pulses
  a_wr_pulse : assert property (@(posedge clk) disable iff (reset)
    cmd.wr_valid |=> !cmd.wr_valid);

endmodule

/* hw/osd_buffer.sv */
// character buffer, one write port and a registered read port; no read-during-write bypass
`timescale 1ns/10ps
`include "osd_params.svh"

module osd_buffer (
  input  logic               clk,
  osd_cmd_if.buffer          cmd,
  input  osd_pkg::buf_addr_t rd_addr,
  output osd_pkg::byte_t     rd_data
);

  // one byte per column, rows of 256
  osd_pkg::byte_t mem [`OSD_BUF_DEPTH];

  // write side, streamed buffer bytes only
  always_ff @(posedge clk) begin
    if (cmd.wr_valid && cmd.wr_target == osd_pkg::TGT_BUF) begin
      mem[cmd.wr_addr] <= cmd.wr_data;
    end
  end

  // --------------------
  // read side
  // --------------------
  // one clock latency, every cycle
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  a_wr_addr_range : assert property (@(posedge clk)
    cmd.wr_valid && cmd.wr_target == osd_pkg::TGT_BUF |-> cmd.wr_addr < `OSD_BUF_DEPTH);

endmodule

/* hw/osd_pixel_gen.sv */
// window and pixel; outputs lag the beam by two clocks, enable changes only at frame start
`timescale 1ns/10ps
`include "osd_params.svh"

module osd_pixel_gen (
  input  logic                clk,
  input  logic                reset,
  input  osd_pkg::h_count_t   h_count,
  input  osd_pkg::v_count_t   v_count,
  input  logic                frame_start,
  input  logic                osd_enable,
  input  osd_pkg::highlight_t highlight,
  input  osd_pkg::byte_t      rd_data,
  output osd_pkg::buf_addr_t  rd_addr,
  output logic                osd_blank,
  output logic                osd_pixel
);

  osd_pkg::h_count_t h_off;
  osd_pkg::v_count_t v_off;
  logic [$clog2(`OSD_ROWS)-1:0] row;
  logic [7:0]        col;
  logic              window;
  logic              invert;
  logic              en_frame;
  // stage aligned with rd_data
  logic              window_d;
  logic              invert_d;
  logic [2:0]        bit_d;

  // --------------------
  // window and address
  // --------------------
  assign h_off  = h_count - osd_pkg::h_count_t'(`OSD_H_START);
  assign v_off  = v_count - osd_pkg::v_count_t'(`OSD_V_START);
  assign row    = v_off[5:3];
  // two clocks per pixel
  assign col    = h_off[8:1];
  assign window = en_frame &&
                  h_count >= `OSD_H_START && h_count < `OSD_H_START + `OSD_H_LEN &&
                  v_count >= `OSD_V_START && v_count < `OSD_V_START + `OSD_V_LEN;
  assign invert = !highlight[3] && highlight[2:0] == row;
  assign rd_addr = osd_pkg::buf_addr_t'(row * `OSD_COLS + col);

  always_ff @(posedge clk) begin
    if (reset) begin
      en_frame  <= 1'b0;
      window_d  <= 1'b0;
      osd_blank <= 1'b0;
      osd_pixel <= 1'b0;
    end else begin
      // enable only taken at frame start
      if (frame_start) begin
        en_frame <= osd_enable;
      end
      window_d  <= window;
      osd_blank <= window_d;
      // line within the row picks the bit, forced low outside
      osd_pixel <= window_d && (rd_data[bit_d] ^ invert_d);
    end
  end

  always_ff @(posedge clk) begin
    invert_d <= invert;
    bit_d    <= v_off[2:0];
  end

endmodule

/* hw/osd_top.sv */
// osd command path top; bytes arrive deframed, no back-pressure, all logic on every clk
`timescale 1ns/10ps

module osd_top (
  input  logic           clk,
  input  logic           reset,
  // byte strobes
  input  logic           rx_valid,
  input  logic           rx_cmd,
  input  osd_pkg::byte_t rx_data,
  // video timing
  input  logic           sol,
  input  logic           sof,
  output logic           osd_blank,
  output logic           osd_pixel,
  // machine settings
  output logic           osd_enable,
  output logic           key_disable,
  output logic           usr_reset,
  output logic           cpu_reset,
  output logic           cpu_halt,
  output logic [1:0]     lr_filter,
  output logic [1:0]     hr_filter,
  output logic [1:0]     scanline,
  output logic [3:0]     chipset_config,
  output logic [3:0]     cpu_config,
  output logic [5:0]     memory_config,
  output logic [3:0]     floppy_config,
  output logic [2:0]     ide_config,
  output logic [1:0]     autofire_config
);

  osd_pkg::h_count_t   h_count;
  osd_pkg::v_count_t   v_count;
  logic                frame_start;
  osd_pkg::highlight_t highlight;
  osd_pkg::buf_addr_t  rd_addr;
  osd_pkg::byte_t      rd_data;

  osd_cmd_if cmd_if ();

  osd_cmd_fsm osd_cmd_fsm_inst (.clk(clk), .reset(reset), .rx_valid(rx_valid),
    .rx_cmd(rx_cmd), .rx_data(rx_data), .cmd(cmd_if));

  osd_beam_counter osd_beam_counter_inst (.clk(clk), .reset(reset), .sol(sol), .sof(sof),
    .h_count(h_count), .v_count(v_count), .frame_start(frame_start));

  osd_config_regs osd_config_regs_inst (.clk(clk), .reset(reset), .cmd(cmd_if),
    .osd_enable(osd_enable), .key_disable(key_disable), .usr_reset(usr_reset),
    .cpu_reset(cpu_reset), .cpu_halt(cpu_halt), .lr_filter(lr_filter),
    .hr_filter(hr_filter), .scanline(scanline), .chipset_config(chipset_config),
    .cpu_config(cpu_config), .memory_config(memory_config),
    .floppy_config(floppy_config), .ide_config(ide_config),
    .autofire_config(autofire_config), .highlight(highlight));

  osd_buffer osd_buffer_inst (.clk(clk), .cmd(cmd_if), .rd_addr(rd_addr), .rd_data(rd_data));

  osd_pixel_gen osd_pixel_gen_inst (.clk(clk), .reset(reset), .h_count(h_count),
    .v_count(v_count), .frame_start(frame_start), .osd_enable(osd_enable),
    .highlight(highlight), .rd_data(rd_data), .rd_addr(rd_addr),
    .osd_blank(osd_blank), .osd_pixel(osd_pixel));

endmodule

/* verification/osd_tb.sv */
// osd_top testbench; xorshift stimulus from seed 90, frames of 200 lines x 1500 clocks, byte strobes 5 clocks apart
`timescale 1ns/10ps
`include "osd_params.svh"

module osd_tb;

  localparam int line_clks   = 1500;
  localparam int frame_lines = 200;
  localparam int num_frames  = 3;
  // frames plus room for register and buffer traffic
  localparam int unsigned watchdog_cycles = num_frames * frame_lines * line_clks + 100000;

  logic           clk = 1'b0;
  logic           reset;
  logic           rx_valid;
  logic           rx_cmd;
  osd_pkg::byte_t rx_data;
  logic           sol;
  logic           sof;
  logic           osd_blank, osd_pixel, osd_enable, key_disable, usr_reset, cpu_reset, cpu_halt;
  logic [1:0]     lr_filter, hr_filter, scanline, autofire_config;
  logic [3:0]     chipset_config, cpu_config, floppy_config;
  logic [5:0]     memory_config;
  logic [2:0]     ide_config;

  // --------------------
  // reference model
  // --------------------
  logic       e_osd_en, e_key_dis, e_usr_reset, e_cpu_reset, e_cpu_halt, s_chip1;
  logic [1:0] e_lr, e_hr, e_scan, e_auto;
  logic [3:0] e_chip, e_cpu, e_floppy, s_cpu, e_hl;
  logic [5:0] e_mem, s_mem;
  logic [2:0] e_ide, s_ide;
  osd_pkg::byte_t      m_buf [`OSD_BUF_DEPTH];
  osd_pkg::cmd_state_t m_state;
  osd_pkg::cmd_code_t  m_code;
  int                  m_addr;
  // beam position and frame enable as the dut should hold them
  osd_pkg::h_count_t   m_h;
  osd_pkg::v_count_t   m_v;
  logic                m_fs, m_en;
  // expected video, bit 1 is due at the next check
  logic [1:0]          exp_blank, exp_pix;
  int                  blanks;
  logic [31:0]         rng = 32'd90;
  osd_pkg::cmd_code_t  cfg_codes [9] = '{osd_pkg::RESET_CTRL, osd_pkg::OSD_CTRL,
    osd_pkg::CHIP_CFG, osd_pkg::CPU_CFG, osd_pkg::MEMORY_CFG, osd_pkg::VIDEO_CFG,
    osd_pkg::FLOPPY_CFG, osd_pkg::HARDDISK_CFG, osd_pkg::JOYSTICK_CFG};

  osd_top osd_top_inst (.clk(clk), .reset(reset), .rx_valid(rx_valid), .rx_cmd(rx_cmd),
    .rx_data(rx_data), .sol(sol), .sof(sof), .osd_blank(osd_blank), .osd_pixel(osd_pixel),
    .osd_enable(osd_enable), .key_disable(key_disable), .usr_reset(usr_reset),
    .cpu_reset(cpu_reset), .cpu_halt(cpu_halt), .lr_filter(lr_filter),
    .hr_filter(hr_filter), .scanline(scanline), .chipset_config(chipset_config),
    .cpu_config(cpu_config), .memory_config(memory_config), .floppy_config(floppy_config),
    .ide_config(ide_config), .autofire_config(autofire_config));

  // 8 ns period
  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic known_code(input logic [5:0] c);
    return c inside {osd_pkg::RESET_CTRL, osd_pkg::OSD_CTRL, osd_pkg::CHIP_CFG,
      osd_pkg::CPU_CFG, osd_pkg::MEMORY_CFG, osd_pkg::VIDEO_CFG, osd_pkg::FLOPPY_CFG,
      osd_pkg::HARDDISK_CFG, osd_pkg::JOYSTICK_CFG, osd_pkg::OSD_BUFFER};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("ERR %0t %s: got %0h, expected %0h", $time, what, got, want);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_outputs;
    check_value("reset control", {cpu_halt, cpu_reset, usr_reset},
      {e_cpu_halt, e_cpu_reset, e_usr_reset});
    check_value("osd control", {key_disable, osd_enable}, {e_key_dis, e_osd_en});
    check_value("video config", {hr_filter, lr_filter, scanline}, {e_hr, e_lr, e_scan});
    check_value("chipset_config", chipset_config, e_chip);
    check_value("cpu_config", cpu_config, e_cpu);
    check_value("memory_config", memory_config, e_mem);
    check_value("floppy_config", floppy_config, e_floppy);
    check_value("ide_config", ide_config, e_ide);
    check_value("autofire_config", autofire_config, e_auto);
  endtask

  // one clock; the beam model follows the inputs sampled at this edge
  task automatic tick;
    logic win;
    logic pix;
    int   row;
    int   col;
    int   line_bit;
    @(posedge clk);
    #1;
    if (reset) begin
      m_en = 1'b0;
    end else if (m_fs) begin
      m_en = e_osd_en;
    end
    m_fs = !reset && sof;
    if (reset || sol) begin
      m_h = '0;
    end else begin
      m_h = m_h + 1'b1;
    end
    if (reset || sof) begin
      m_v = '0;
    end else if (sol) begin
      m_v = m_v + 1'b1;
    end
    // outputs lag the beam by two clocks
    check_value("osd_blank", osd_blank, exp_blank[1]);
    check_value("osd_pixel", osd_pixel, exp_pix[1]);
    if (osd_blank) begin
      blanks++;
    end
    win = m_en && m_h >= `OSD_H_START && m_h < `OSD_H_START + `OSD_H_LEN &&
          m_v >= `OSD_V_START && m_v < `OSD_V_START + `OSD_V_LEN;
    pix = 1'b0;
    if (win) begin
      row      = (m_v - `OSD_V_START) / 8;
      col      = (m_h - `OSD_H_START) / 2;
      line_bit = (m_v - `OSD_V_START) % 8;
      // highlighted row is drawn inverted
      pix = m_buf[row * `OSD_COLS + col][line_bit] ^ (!e_hl[3] && e_hl[2:0] == row);
    end
    exp_blank = {exp_blank[0], win};
    exp_pix   = {exp_pix[0], pix};
  endtask

  task automatic apply_reg(input osd_pkg::cmd_code_t code, input osd_pkg::byte_t d);
    case (code)
      osd_pkg::RESET_CTRL: {e_cpu_halt, e_cpu_reset, e_usr_reset} = d[2:0];
      osd_pkg::OSD_CTRL:   {e_key_dis, e_osd_en} = d[1:0];
      osd_pkg::CHIP_CFG: begin
        e_chip[3:2] = d[3:2];
        e_chip[0]   = d[0];
        s_chip1     = d[1];
      end
      osd_pkg::CPU_CFG:      s_cpu = d[3:0];
      osd_pkg::MEMORY_CFG:   s_mem = d[5:0];
      osd_pkg::VIDEO_CFG:    {e_hr, e_lr, e_scan} = d[5:0];
      osd_pkg::FLOPPY_CFG:   e_floppy = d[3:0];
      osd_pkg::HARDDISK_CFG: s_ide = d[2:0];
      osd_pkg::JOYSTICK_CFG: e_auto = d[1:0];
      default: ;
    endcase
  endtask

  // decoder, register bank and buffer image after one byte
  task automatic model_byte(input logic is_cmd, input osd_pkg::byte_t d);
    if (is_cmd) begin
      m_code = osd_pkg::cmd_code_t'(d[7:2]);
      if (d[7:2] == osd_pkg::OSD_BUFFER) begin
        m_state = osd_pkg::ST_LINE;
      end else if (known_code(d[7:2])) begin
        m_state = osd_pkg::ST_REG;
      end else begin
        m_state = osd_pkg::ST_IGNORE;
      end
    end else begin
      case (m_state)
        osd_pkg::ST_REG: begin
          apply_reg(m_code, d);
          m_state = osd_pkg::ST_IGNORE;
        end
        osd_pkg::ST_LINE: begin
          if (e_osd_en && d[4]) begin
            e_hl = d[3:0];
          end
          m_addr  = d[2:0] * `OSD_COLS;
          m_state = osd_pkg::ST_STREAM;
        end
        osd_pkg::ST_STREAM: begin
          m_buf[m_addr] = d;
          m_addr        = m_addr + 1;
        end
        default: ;
      endcase
    end
    // staged settings follow while the cpu is held in reset
    if (e_cpu_reset) begin
      e_chip[1] = s_chip1;
      e_cpu     = s_cpu;
      e_mem     = s_mem;
      e_ide     = s_ide;
    end
    if (!e_osd_en) begin
      e_hl = `OSD_HIGHLIGHT_NONE;
    end
  endtask

  task automatic send_byte(input logic is_cmd, input osd_pkg::byte_t d);
    tick;
    rx_valid = 1'b1;
    rx_cmd   = is_cmd;
    rx_data  = d;
    tick;
    // junk on the bus while no strobe
    rx_valid = 1'b0;
    rx_cmd   = next_rand() & 1;
    rx_data  = osd_pkg::byte_t'(next_rand());
    model_byte(is_cmd, d);
    // plain registers settle 2 clocks after the strobe, staged ones 3
    repeat (3) tick;
    check_outputs;
  endtask

  task automatic write_reg(input osd_pkg::cmd_code_t code, input osd_pkg::byte_t d);
    logic [31:0] r;
    r = next_rand();
    send_byte(1'b1, {code, r[1:0]});
    send_byte(1'b0, d);
  endtask

  task automatic run_frame;
    blanks = 0;
    for (int ln = 0; ln < frame_lines; ln++) begin
      for (int c = 0; c < line_clks; c++) begin
        tick;
        sol = (c == 0);
        sof = (c == 0 && ln == 0);
      end
    end
  endtask

  // --------------------
  // stimulus
  // --------------------
  initial begin
    logic [31:0]    r;
    osd_pkg::byte_t d;
    int             hl_row;
    reset    = 1'b1;
    rx_valid = 1'b0;
    rx_cmd   = 1'b0;
    rx_data  = '0;
    sol      = 1'b0;
    sof      = 1'b0;
    {e_cpu_halt, e_cpu_reset, e_usr_reset} = 3'b110;
    {e_key_dis, e_osd_en} = 2'b00;
    {e_hr, e_lr, e_scan}  = 6'd0;
    {e_chip, e_cpu, e_floppy, e_ide, e_auto} = '0;
    {s_chip1, s_cpu, s_ide} = '0;
    e_mem     = `OSD_MEM_CFG_RESET;
    s_mem     = `OSD_MEM_CFG_RESET;
    e_hl      = `OSD_HIGHLIGHT_NONE;
    m_state   = osd_pkg::ST_IDLE;
    m_code    = osd_pkg::RESET_CTRL;
    m_addr    = 0;
    {m_h, m_v, m_fs, m_en} = '0;
    exp_blank = '0;
    exp_pix   = '0;
    blanks    = 0;
    repeat (2) tick;
    reset = 1'b0;
    tick;
    check_outputs;
    // random config writes, unknown codes and stray data bytes
    for (int i = 0; i < 60; i++) begin
      r = next_rand();
      if (r[2:0] == 3'd0) begin
        do begin
          r = next_rand();
        end while (known_code(r[7:2]));
        send_byte(1'b1, r[7:0]);
      end else begin
        send_byte(1'b1, {cfg_codes[r[7:4] % 9], r[1:0]});
      end
      send_byte(1'b0, osd_pkg::byte_t'(next_rand()));
      if (r[9:8] == 2'd0) begin
        send_byte(1'b0, osd_pkg::byte_t'(next_rand()));
      end
    end
    // staged settings held while cpu runs, last one wins under reset
    write_reg(osd_pkg::RESET_CTRL, 8'h00);
    write_reg(osd_pkg::CPU_CFG, osd_pkg::byte_t'(next_rand()));
    write_reg(osd_pkg::MEMORY_CFG, osd_pkg::byte_t'(next_rand()));
    write_reg(osd_pkg::HARDDISK_CFG, osd_pkg::byte_t'(next_rand()));
    write_reg(osd_pkg::CHIP_CFG, osd_pkg::byte_t'(next_rand()));
    write_reg(osd_pkg::CPU_CFG, osd_pkg::byte_t'(next_rand()));
    write_reg(osd_pkg::RESET_CTRL, 8'h02);
    // fill all lines, the chosen row also gets the highlight
    write_reg(osd_pkg::OSD_CTRL, 8'h01);
    hl_row = next_rand() % 8;
    for (int ln = 0; ln < `OSD_ROWS; ln++) begin
      d = osd_pkg::byte_t'(ln);
      if (ln == hl_row) begin
        d[4] = 1'b1;
      end
      send_byte(1'b1, {osd_pkg::OSD_BUFFER, 2'b00});
      send_byte(1'b0, d);
      for (int c = 0; c < `OSD_COLS; c++) begin
        send_byte(1'b0, osd_pkg::byte_t'(next_rand()));
      end
    end
    run_frame;
    check_value("window size, osd on", blanks, `OSD_H_LEN * `OSD_V_LEN);
    write_reg(osd_pkg::OSD_CTRL, 8'h00);
    run_frame;
    check_value("window size, osd off", blanks, 0);
    // highlight was dropped with the enable
    write_reg(osd_pkg::OSD_CTRL, 8'h01);
    run_frame;
    check_value("window size, osd back on", blanks, `OSD_H_LEN * `OSD_V_LEN);
    $display("All tests passed");
    $finish;
  end

  initial begin
    #(watchdog_cycles * 8);
    $display("timeout: the run took longer than its frames and register traffic allow");
    $display("Some tests failed");
    $fatal(1);
  end

endmodule

/* sim.f */
+incdir+include
hw/osd_pkg.sv
hw/osd_cmd_if.sv
hw/osd_cmd_fsm.sv
hw/osd_beam_counter.sv
hw/osd_config_regs.sv
hw/osd_buffer.sv
hw/osd_pixel_gen.sv
hw/osd_top.sv
verification/osd_tb.sv

/* Bender.yml */
package:
  name: osd_ctrl

sources:
  - include_dirs:
      - include
    files:
      - hw/osd_pkg.sv
      - hw/osd_cmd_if.sv
      - hw/osd_cmd_fsm.sv
      - hw/osd_beam_counter.sv
      - hw/osd_config_regs.sv
      - hw/osd_buffer.sv
      - hw/osd_pixel_gen.sv
      - hw/osd_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/osd_tb.sv
